/* compile.f */
verilog/sm83_pkg.sv
verilog/sm83_alu.sv
verilog/sm83_regfile.sv
verilog/sm83_pc_unit.sv
verilog/sm83_decoder.sv
verilog/sm83_core.sv
bench/sm83_mem_model.sv
bench/tb_sm83_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SM83 core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/100ps -f compile.f \
    --top-module tb_sm83_core -Mdir obj_dir; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_sm83_core > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  exit 0
fi
exit 1

/* bench/tb_sm83_core.sv */
`timescale 1ns/100ps

module tb_sm83_core
  import sm83_pkg::*;
();

  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 6;
  // Sum of the six program lengths from the cycle table
  localparam int TEST_CYCLES  = 32 + 22 + 47 + 19 + 25 + 13;
  localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES + NUM_TESTS * RESET_CYCLES;

  logic              clk;
  logic              rst;
  logic [DATA_W-1:0] mem_rdata;
  logic [ADDR_W-1:0] mem_addr;
  logic [DATA_W-1:0] mem_wdata;
  logic              mem_rd;
  logic              mem_wr;

  logic [DATA_W-1:0] prog [$];
  logic [DATA_W-1:0] exp_data [$];
  int                value_errs = 0;
  int                other_errs = 0;
  int                cycle_count = 0;

  sm83_core uut (
    .clk       (clk),
    .rst       (rst),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr)
  );

  sm83_mem_model ram (
    .clk   (clk),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .wr    (mem_wr),
    .rdata (mem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, the tests did not complete", CYCLE_LIMIT);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Core held in reset while the program goes in at address 0
  task automatic load_program();
    @(negedge clk);
    rst = 1'b1;
    ram.clear_all();
    foreach (prog[i]) begin
      ram.cells[ADDR_W'(i)] = prog[i];
    end
  endtask

  // All stores of a program go to one HL address
  task automatic run_and_check(input logic [ADDR_W-1:0] store_addr, input int cycles);
    repeat (RESET_CYCLES) @(negedge clk);
    assert (ram.log_addr.size() == 0) else begin
      other_errs++;
      $display("Memory was written while reset was held");
    end
    rst = 1'b0;
    assert (mem_rd && mem_addr == RESET_PC) else begin
      value_errs++;
      $display("ERR %0t: first access at %h with rd=%b, expected a read at %h",
               $time, mem_addr, mem_rd, RESET_PC);
    end
    // One cycle short of the end the last store is still pending
    repeat (cycles - 1) @(negedge clk);
    assert (ram.log_addr.size() == exp_data.size() - 1) else begin
      other_errs++;
      $display("One cycle before the end %0d writes were logged instead of %0d",
               ram.log_addr.size(), exp_data.size() - 1);
    end
    @(negedge clk);
    assert (ram.log_addr.size() == exp_data.size()) else begin
      other_errs++;
      $display("Program made %0d writes but %0d were expected",
               ram.log_addr.size(), exp_data.size());
    end
    foreach (exp_data[i]) begin
      if (i < ram.log_addr.size()) begin
        assert (ram.log_addr[i] == store_addr && ram.log_data[i] == exp_data[i]) else begin
          value_errs++;
          $display("ERR %0t: write %0d at %h data %h, expected at %h data %h", $time, i,
                   ram.log_addr[i], ram.log_data[i], store_addr, exp_data[i]);
        end
      end
    end
  endtask

  task automatic immediate_loads_and_stores();
    prog = '{8'h06, 8'h11, 8'h0E, 8'h22, 8'h16, 8'h33, 8'h1E, 8'h44, 8'h26, 8'h66,
             8'h2E, 8'h77, 8'h3E, 8'h55, 8'h26, 8'hC0, 8'h2E, 8'h10,
             8'h70, 8'h71, 8'h72, 8'h73, 8'h74, 8'h75, 8'h77};
    // H and L hold the reloaded address bytes
    exp_data = '{8'h11, 8'h22, 8'h33, 8'h44, 8'hC0, 8'h10, 8'h55};
    load_program();
    run_and_check(16'hC010, 9 * 2 + 7 * 2);
  endtask

  task automatic register_moves();
    // LD D,B  LD E,C  LD A,D  LD B,E then store A, B, C, D, E
    prog = '{8'h06, 8'h5A, 8'h0E, 8'hA5, 8'h26, 8'hC0, 8'h2E, 8'h20,
             8'h50, 8'h59, 8'h7A, 8'h43, 8'h77, 8'h70, 8'h71, 8'h72, 8'h73};
    exp_data = '{8'h5A, 8'hA5, 8'hA5, 8'h5A, 8'hA5};
    load_program();
    run_and_check(16'hC020, 9 * 2 + 4);
  endtask

  task automatic alu_operations();
    prog = '{8'h06, 8'h0F, 8'h26, 8'hC0, 8'h2E, 8'h30, 8'h3E, 8'h3C,
             8'h80, 8'h77, 8'hC6, 8'hF0, 8'hCE, 8'h00, 8'h77,
             8'hD6, 8'h0C, 8'h77, 8'hD6, 8'h40, 8'hDE, 8'h00, 8'h77,
             8'hA0, 8'hCE, 8'h00, 8'h77, 8'hEE, 8'hFF, 8'h77, 8'hB0, 8'h77,
             8'h3E, 8'h10, 8'hFE, 8'h20, 8'hCE, 8'h00, 8'h77};
    // 3C+0F, then 4B+F0 carries so ADC 0 gives 3B+1
    // 3C-0C, then 30-40 borrows so SBC 0 gives F0-1
    // AND clears carry, XOR FF, OR B, and CP 10-20 borrows with A kept at 10
    exp_data = '{8'h4B, 8'h3C, 8'h30, 8'hEF, 8'h0F, 8'hF0, 8'hFF, 8'h11};
    load_program();
    run_and_check(16'hC030, 22 * 2 + 3);
  endtask

  task automatic memory_operands();
    // LD B,[HL]  ADD A,[HL] on 27, then stores at C041 ending with LD [HL],9D
    prog = '{8'h26, 8'hC0, 8'h2E, 8'h40, 8'h46, 8'h3E, 8'h15, 8'h86,
             8'h2E, 8'h41, 8'h70, 8'h77, 8'h36, 8'h9D};
    exp_data = '{8'h27, 8'h3C, 8'h9D};
    load_program();
    ram.cells[16'hC040] = 8'h27;
    run_and_check(16'hC041, 8 * 2 + 3);
  endtask

  task automatic increment_decrement();
    // INC B on FF, DEC C on 00, then INC D between a carrying ADD and ADC 0
    prog = '{8'h26, 8'hC0, 8'h2E, 8'h50, 8'h06, 8'hFF, 8'h04, 8'h0E, 8'h00, 8'h0D,
             8'h70, 8'h71, 8'h3E, 8'hF0, 8'hC6, 8'h20, 8'h14, 8'hCE, 8'h00,
             8'h77, 8'h72};
    exp_data = '{8'h00, 8'hFF, 8'h11, 8'h01};
    load_program();
    run_and_check(16'hC050, 11 * 2 + 3);
  endtask

  task automatic unknown_opcodes();
    // RLCA, CCF and INC [HL] are dropped, so A and carry stay as loaded
    prog = '{8'h26, 8'hC0, 8'h2E, 8'h60, 8'h3E, 8'h42, 8'h07, 8'h3F, 8'h34,
             8'hCE, 8'h00, 8'h77};
    exp_data = '{8'h42};
    load_program();
    run_and_check(16'hC060, 5 * 2 + 3);
  endtask

  initial begin
    rst = 1'b1;
    immediate_loads_and_stores();
    register_moves();
    alu_operations();
    memory_operands();
    increment_decrement();
    unknown_opcodes();
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* bench/sm83_mem_model.sv */
`timescale 1ns/100ps

module sm83_mem_model
  import sm83_pkg::*;
(
  input  logic              clk,
  input  logic [ADDR_W-1:0] addr,
  input  logic [DATA_W-1:0] wdata,
  input  logic              wr,
  output logic [DATA_W-1:0] rdata
);

  logic [DATA_W-1:0] cells [2**ADDR_W];

  // Every write in order, read back by the testbench
  logic [ADDR_W-1:0] log_addr [$];
  logic [DATA_W-1:0] log_data [$];

  // Always ready, read data follows the address
  assign rdata = cells[addr];

  always @(posedge clk) begin
    if (wr) begin
      cells[addr] = wdata;
      log_addr.push_back(addr);
      log_data.push_back(wdata);
    end
  end

  task automatic clear_all();
    for (int i = 0; i < 2**ADDR_W; i++) begin
      cells[ADDR_W'(i)] = '0;
    end
    log_addr.delete();
    log_data.delete();
  endtask

endmodule

/* verilog/sm83_core.sv */
`timescale 1ns/100ps

module sm83_core
  import sm83_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic [ADDR_W-1:0] mem_addr,
  output logic [DATA_W-1:0] mem_wdata,
  output logic              mem_rd,
  output logic              mem_wr
);

  // Decoder control
  logic      pc_inc;
  addr_sel_t addr_sel;
  logic      rf_we;
  reg_sel_t  rf_wsel;
  wsrc_t     rf_wsrc;
  reg_sel_t  rf_rsel;
  logic      flags_we;
  alu_op_t   alu_op;

  // Datapath
  logic [DATA_W-1:0] reg_a;
  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] alu_result;
  logic [ADDR_W-1:0] hl;
  flags_t            flags;
  flags_t            alu_flags;

  assign mem_wdata = rdata;

  sm83_decoder u_decoder (
    .clk       (clk),
    .rst       (rst),
    .mem_rdata (mem_rdata),
    .mem_rd    (mem_rd),
    .mem_wr    (mem_wr),
    .pc_inc    (pc_inc),
    .addr_sel  (addr_sel),
    .rf_we     (rf_we),
    .rf_wsel   (rf_wsel),
    .rf_wsrc   (rf_wsrc),
    .rf_rsel   (rf_rsel),
    .flags_we  (flags_we),
    .alu_op    (alu_op)
  );

  sm83_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .rf_we      (rf_we),
    .rf_wsel    (rf_wsel),
    .rf_wsrc    (rf_wsrc),
    .rf_rsel    (rf_rsel),
    .flags_we   (flags_we),
    .alu_result (alu_result),
    .alu_flags  (alu_flags),
    .mem_rdata  (mem_rdata),
    .rdata      (rdata),
    .reg_a      (reg_a),
    .hl         (hl),
    .flags      (flags)
  );

  sm83_alu u_alu (
    .alu_op     (alu_op),
    .reg_a      (reg_a),
    .rdata      (rdata),
    .flags      (flags),
    .alu_result (alu_result),
    .alu_flags  (alu_flags)
  );

  sm83_pc_unit u_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .pc_inc   (pc_inc),
    .addr_sel (addr_sel),
    .hl       (hl),
    .mem_addr (mem_addr)
  );

endmodule

/* verilog/sm83_decoder.sv */
`timescale 1ns/100ps

module sm83_decoder
  import sm83_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic              mem_rd,
  output logic              mem_wr,
  output logic              pc_inc,
  output addr_sel_t         addr_sel,
  output logic              rf_we,
  output reg_sel_t          rf_wsel,
  output wsrc_t             rf_wsrc,
  output reg_sel_t          rf_rsel,
  output logic              flags_we,
  output alu_op_t           alu_op
);

  logic [DATA_W-1:0] ir;
  logic [1:0]        m_cycle;
  logic [1:0]        m_cycle_next;
  logic [2:0]        dst;
  logic [2:0]        src;

  // Last M-cycle an opcode needs before the next fetch
  function automatic logic [1:0] last_mcycle(input logic [DATA_W-1:0] op);
    logic [2:0] d;
    logic [2:0] s;
    d = op[5:3];
    s = op[2:0];
    last_mcycle = 2'd0;
    case (op[7:6])
      2'b00: begin
        // LD r,n and LD [HL],n
        if (s == HL_CODE) begin
          last_mcycle = (d == HL_CODE) ? 2'd2 : 2'd1;
        end
      end
      2'b01: begin
        // One side of the move is [HL], both sides is HALT
        if ((d == HL_CODE) != (s == HL_CODE)) begin
          last_mcycle = 2'd1;
        end
      end
      default: begin
        // ALU op on [HL] or on an immediate
        if (s == HL_CODE) begin
          last_mcycle = 2'd1;
        end
      end
    endcase
  endfunction

  assign dst = ir[5:3];
  assign src = ir[2:0];

  always_comb begin
    case (m_cycle)
      2'd0:    m_cycle_next = (last_mcycle(mem_rdata) != 2'd0) ? 2'd1 : 2'd0;
      2'd1:    m_cycle_next = (last_mcycle(ir) == 2'd2) ? 2'd2 : 2'd0;
      default: m_cycle_next = 2'd0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      m_cycle <= 2'd0;
      ir      <= '0;
    end else begin
      m_cycle <= m_cycle_next;
      if (m_cycle == 2'd0) begin
        ir <= mem_rdata;
      end
    end
  end

  always_comb begin
    mem_rd   = 1'b0;
    mem_wr   = 1'b0;
    pc_inc   = 1'b0;
    addr_sel = ADDR_PC;
    rf_we    = 1'b0;
    rf_wsel  = REG_A;
    rf_wsrc  = WSRC_ALU;
    rf_rsel  = REG_Z;
    flags_we = 1'b0;
    alu_op   = ALU_PASS;

    case (m_cycle)
      2'd0: begin
        // Fetch, while ir still holds the instruction being finished
        mem_rd = 1'b1;
        pc_inc = 1'b1;
        if (ir[7:6] == 2'b00 && src[2:1] == 2'b10 && dst != HL_CODE) begin
          // INC r / DEC r keep the carry
          rf_rsel  = reg_sel_t'(dst);
          rf_wsel  = reg_sel_t'(dst);
          alu_op   = src[0] ? ALU_DEC : ALU_INC;
          rf_we    = 1'b1;
          flags_we = 1'b1;
        end else if (ir[7:6] == 2'b00 && src == HL_CODE && dst != HL_CODE) begin
          // LD r,n from Z
          rf_wsel = reg_sel_t'(dst);
          rf_we   = 1'b1;
        end else if (ir[7:6] == 2'b01 && dst != HL_CODE) begin
          // LD r,r' and LD r,[HL], the Z code reads the loaded byte
          rf_rsel = reg_sel_t'(src);
          rf_wsel = reg_sel_t'(dst);
          rf_we   = 1'b1;
        end else if (ir[7:6] == 2'b10 || (ir[7:6] == 2'b11 && src == HL_CODE)) begin
          rf_rsel  = reg_sel_t'(src);
          alu_op   = alu_op_t'({1'b0, dst});
          flags_we = 1'b1;
          rf_we    = (alu_op != ALU_CP);
        end
      end
      2'd1: begin
        if (ir[7:6] == 2'b01 && dst == HL_CODE) begin
          // LD [HL],r
          mem_wr   = 1'b1;
          addr_sel = ADDR_HL;
          rf_rsel  = reg_sel_t'(src);
        end else begin
          // Operand byte into Z
          mem_rd  = 1'b1;
          rf_we   = 1'b1;
          rf_wsel = REG_Z;
          rf_wsrc = WSRC_MEM;
          if (ir[7] == ir[6]) begin
            pc_inc = 1'b1;
          end else begin
            addr_sel = ADDR_HL;
          end
        end
      end
      default: begin
        // LD [HL],n stores the immediate held in Z
        mem_wr   = 1'b1;
        addr_sel = ADDR_HL;
        rf_rsel  = REG_Z;
      end
    endcase
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst) !(mem_rd && mem_wr));

  a_mcycle_max: assert property (@(posedge clk) disable iff (rst) m_cycle <= 2'd2);

endmodule

/* verilog/sm83_pc_unit.sv */
`timescale 1ns/100ps

module sm83_pc_unit
  import sm83_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              pc_inc,
  input  addr_sel_t         addr_sel,
  input  logic [ADDR_W-1:0] hl,
  output logic [ADDR_W-1:0] mem_addr
);

  logic [ADDR_W-1:0] pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (pc_inc) begin
      pc <= pc + ADDR_W'(1);
    end
  end

  // Opcode and immediate reads use PC, operand accesses use HL
  assign mem_addr = (addr_sel == ADDR_HL) ? hl : pc;

  // PC only advances past bytes it has just addressed
  a_inc_on_pc: assert property (@(posedge clk) disable iff (rst)
    pc_inc |-> addr_sel == ADDR_PC);

endmodule

/* verilog/sm83_regfile.sv */
`timescale 1ns/100ps

module sm83_regfile
  import sm83_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              rf_we,
  input  reg_sel_t          rf_wsel,
  input  wsrc_t             rf_wsrc,
  input  reg_sel_t          rf_rsel,
  input  logic              flags_we,
  input  logic [DATA_W-1:0] alu_result,
  input  flags_t            alu_flags,
  input  logic [DATA_W-1:0] mem_rdata,
  output logic [DATA_W-1:0] rdata,
  output logic [DATA_W-1:0] reg_a,
  output logic [ADDR_W-1:0] hl,
  output flags_t            flags
);

  // B, C, D, E, H, L, Z, A indexed by reg_sel_t
  logic [DATA_W-1:0] regs [8];
  logic [DATA_W-1:0] wdata;

  // Write source mux
  assign wdata = (rf_wsrc == WSRC_MEM) ? mem_rdata : alu_result;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (rf_we) begin
        regs[rf_wsel] <= wdata;
      end
      if (flags_we) begin
        flags <= alu_flags;
      end
    end
  end

  // Read port also feeds the memory write data
  assign rdata = regs[rf_rsel];
  assign reg_a = regs[REG_A];
  assign hl    = {regs[REG_H], regs[REG_L]};

  // Bytes loaded from memory never carry flag updates
  a_no_flags_on_load: assert property (@(posedge clk) disable iff (rst)
    !(flags_we && rf_we && rf_wsrc == WSRC_MEM));

endmodule

/* verilog/sm83_alu.sv */
`timescale 1ns/100ps

module sm83_alu
  import sm83_pkg::*;
(
  input  alu_op_t           alu_op,
  input  logic [DATA_W-1:0] reg_a,
  input  logic [DATA_W-1:0] rdata,
  input  flags_t            flags,
  output logic [DATA_W-1:0] alu_result,
  output flags_t            alu_flags
);

  logic [DATA_W:0] sum;
  logic [4:0]      half;
  logic            cin;

  always_comb begin
    sum        = '0;
    half       = '0;
    cin        = 1'b0;
    alu_result = '0;
    alu_flags  = flags;

    case (alu_op)
      ALU_ADD, ALU_ADC: begin
        cin         = (alu_op == ALU_ADC) && flags.c;
        sum         = {1'b0, reg_a} + {1'b0, rdata} + {{DATA_W{1'b0}}, cin};
        half        = {1'b0, reg_a[3:0]} + {1'b0, rdata[3:0]} + {4'b0, cin};
        alu_result  = sum[DATA_W-1:0];
        alu_flags.n = 1'b0;
        alu_flags.h = half[4];
        alu_flags.c = sum[DATA_W];
      end
      ALU_SUB, ALU_SBC, ALU_CP: begin
        // Top bit of the wrapped difference is the borrow
        cin         = (alu_op == ALU_SBC) && flags.c;
        sum         = {1'b0, reg_a} - {1'b0, rdata} - {{DATA_W{1'b0}}, cin};
        half        = {1'b0, reg_a[3:0]} - {1'b0, rdata[3:0]} - {4'b0, cin};
        alu_result  = sum[DATA_W-1:0];
        alu_flags.n = 1'b1;
        alu_flags.h = half[4];
        alu_flags.c = sum[DATA_W];
      end
      ALU_AND: begin
        alu_result = reg_a & rdata;
        alu_flags  = '{z: 1'b0, n: 1'b0, h: 1'b1, c: 1'b0};
      end
      ALU_XOR: begin
        alu_result = reg_a ^ rdata;
        alu_flags  = '0;
      end
      ALU_OR: begin
        alu_result = reg_a | rdata;
        alu_flags  = '0;
      end
      ALU_INC: begin
        half        = {1'b0, rdata[3:0]} + 5'd1;
        alu_result  = rdata + DATA_W'(1);
        alu_flags.n = 1'b0;
        alu_flags.h = half[4];
      end
      ALU_DEC: begin
        half        = {1'b0, rdata[3:0]} - 5'd1;
        alu_result  = rdata - DATA_W'(1);
        alu_flags.n = 1'b1;
        alu_flags.h = half[4];
      end
      default: begin
        // Register copy
        alu_result = rdata;
      end
    endcase

    if (alu_op != ALU_PASS) begin
      alu_flags.z = (alu_result == '0);
    end
  end

endmodule

/* verilog/sm83_pkg.sv */
package sm83_pkg;

  // Datapath widths
  localparam int DATA_W = 8;
  localparam int ADDR_W = 16;

  // Program counter value after reset
  localparam logic [ADDR_W-1:0] RESET_PC = 16'h0000;

  // Operand field code for [HL], also the Z register code in the core
  localparam logic [2:0] HL_CODE = 3'd6;

  // Register file codes, same order as the opcode operand fields
  typedef enum logic [2:0] {
    REG_B = 3'd0,
    REG_C = 3'd1,
    REG_D = 3'd2,
    REG_E = 3'd3,
    REG_H = 3'd4,
    REG_L = 3'd5,
    REG_Z = HL_CODE,
    REG_A = 3'd7
  } reg_sel_t;

  // First eight codes match opcode bits 5..3 of the ALU group
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_ADC  = 4'd1,
    ALU_SUB  = 4'd2,
    ALU_SBC  = 4'd3,
    ALU_AND  = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_OR   = 4'd6,
    ALU_CP   = 4'd7,
    ALU_INC  = 4'd8,
    ALU_DEC  = 4'd9,
    ALU_PASS = 4'd10
  } alu_op_t;

  typedef struct packed {
    logic z;
    logic n;
    logic h;
    logic c;
  } flags_t;

  // Memory address source
  typedef enum logic {
    ADDR_PC = 1'b0,
    ADDR_HL = 1'b1
  } addr_sel_t;

  // Register write data source
  typedef enum logic {
    WSRC_ALU = 1'b0,
    WSRC_MEM = 1'b1
  } wsrc_t;

endpackage
